//--- verilog/fifo_pkg.sv
package fifo_pkg;

   // --------------------
   // sizes
   // --------------------
   localparam int DATA_W         = 80;                 // stored word width
   localparam int ADDR_W         = 6;                  // pointer width
   localparam int DEPTH          = 1 << ADDR_W;        // ram entries, 64
   localparam int COUNT_W        = ADDR_W + 1;         // count must reach DEPTH
   localparam int FULL_THRESHOLD = 56;                 // full rises at or above this count

   // parity, one even bit per slice, last slice may be short
   localparam int PARITY_SLICE   = 32;
   localparam int PARITY_W       = (DATA_W + PARITY_SLICE - 1) / PARITY_SLICE;

   // --------------------
   // types
   // --------------------
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [COUNT_W-1:0]  count_t;
   typedef logic [PARITY_W-1:0] parity_t;

   // occupancy class, tells the bypass stage where the second word lives
   typedef enum logic [1:0]
   {
      OCC_EMPTY = 2'd0,   // nothing stored
      OCC_ONE   = 2'd1,   // head only, sits in dout
      OCC_TWO   = 2'd2,   // head in dout, second word in din_q
      OCC_MORE  = 2'd3    // second word comes from the ram
   } occ_t;

endpackage

//--- verilog/fifo_ram_if.sv
`timescale 1ns/1ns

// bundle between the fifo controller and the storage ram
interface fifo_ram_if;

   // --------------------
   // write side
   // --------------------
   fifo_pkg::data_t wdata;     // word to store
   fifo_pkg::addr_t waddr;     // write pointer
   logic            we;        // accepted write

   // --------------------
   // read side
   // --------------------
   fifo_pkg::addr_t raddr;     // next read pointer, captured by the ram
   fifo_pkg::data_t rdata;     // valid the cycle after raddr
   logic            perr_raw;  // parity mismatch on rdata, unmasked

   modport ctrl
   (
      output wdata, waddr, we, raddr,
      input  rdata, perr_raw
   );

   modport ram
   (
      input  wdata, waddr, we, raddr,
      output rdata, perr_raw
   );

endinterface

//--- verilog/fifo_ram.sv
`timescale 1ns/1ns

// dual-port storage, write at the edge, read through a registered address
module fifo_ram
(
   input logic       clk,
   fifo_ram_if.ram   mem
);

   // --------------------
   // storage
   // --------------------
   fifo_pkg::data_t   data_mem [fifo_pkg::DEPTH];    // payload
   fifo_pkg::parity_t par_mem  [fifo_pkg::DEPTH];    // parity stored next to it
   fifo_pkg::addr_t   raddr_q;                      // registered read address
   fifo_pkg::parity_t rd_par;                       // stored parity of the word read
   fifo_pkg::parity_t rd_par_calc;                  // parity recomputed on read

   // even parity per slice, bit i lands in slice i / PARITY_SLICE
   function automatic fifo_pkg::parity_t calc_parity(input fifo_pkg::data_t d);
      fifo_pkg::parity_t p;
      p = '0;
      for (int i = 0; i < fifo_pkg::DATA_W; i++)
      begin
         p[i / fifo_pkg::PARITY_SLICE] = p[i / fifo_pkg::PARITY_SLICE] ^ d[i];
      end
      return p;
   endfunction

   // write port, parity generated on the way in
   always_ff @(posedge clk)
   begin
      if (mem.we)
      begin
         data_mem[mem.waddr] <= mem.wdata;
         par_mem[mem.waddr]  <= calc_parity(mem.wdata);
      end
   end

   // read port
   always_ff @(posedge clk)
   begin
      raddr_q <= mem.raddr;   // one cycle of read latency
   end

   // a write landing on raddr_q shows up here right away
   assign mem.rdata = data_mem[raddr_q];
   assign rd_par    = par_mem[raddr_q];

   // --------------------
   // parity check
   // --------------------
   assign rd_par_calc  = calc_parity(mem.rdata);
   assign mem.perr_raw = |(rd_par ^ rd_par_calc);   // any slice off flags the word

endmodule

//--- verilog/fifo_ctrl.sv
`timescale 1ns/1ns

// pointers, occupancy and status for the bypass fifo
module fifo_ctrl
(
   input  logic              clk,
   input  logic              reset,
   input  fifo_pkg::data_t   din,
   input  logic              wen,
   input  logic              ren,
   fifo_ram_if.ctrl          ram,
   output logic              do_write,    // accepted write strobe
   output logic              do_read,     // accepted read strobe
   output fifo_pkg::occ_t    occ,         // class of the current count
   output logic              not_empty,
   output fifo_pkg::count_t  count,
   output logic              full,
   output logic              err,
   output logic              perr
);

   fifo_pkg::addr_t  w_ptr;        // next entry to write
   fifo_pkg::addr_t  r_ptr;        // one ahead of the head word
   fifo_pkg::addr_t  r_ptr_nxt;
   fifo_pkg::count_t count_nxt;
   fifo_pkg::occ_t   occ_nxt;
   logic             can_write;
   logic             refused;      // overflow or underflow this cycle
   logic             ram_rd_en;    // this read takes its word from the ram

   // --------------------
   // strobe qualification
   // --------------------
   assign can_write = count < fifo_pkg::count_t'(fifo_pkg::DEPTH);
   assign do_write  = wen & can_write;
   assign do_read   = ren & not_empty;    // not_empty is registered, no loop
   assign refused   = (wen & ~can_write) | (ren & ~not_empty);

   // only the deep case loads dout from rdata
   assign ram_rd_en = do_read & (occ == fifo_pkg::OCC_MORE);

   // --------------------
   // next state
   // --------------------
   assign r_ptr_nxt = r_ptr + fifo_pkg::addr_t'(do_read);
   assign count_nxt = count + fifo_pkg::count_t'(do_write) - fifo_pkg::count_t'(do_read);

   always_comb
   begin
      if (count_nxt == '0)
         occ_nxt = fifo_pkg::OCC_EMPTY;
      else if (count_nxt == fifo_pkg::count_t'(1))
         occ_nxt = fifo_pkg::OCC_ONE;
      else if (count_nxt == fifo_pkg::count_t'(2))
         occ_nxt = fifo_pkg::OCC_TWO;
      else
         occ_nxt = fifo_pkg::OCC_MORE;   // second word is in the ram by now
   end

   // --------------------
   // ram side
   // --------------------
   assign ram.wdata = din;
   assign ram.waddr = w_ptr;
   assign ram.we    = do_write;     // every accepted word goes to the ram
   assign ram.raddr = r_ptr_nxt;    // prefetch the word behind the head

   // --------------------
   // registers
   // --------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         w_ptr     <= '0;
         r_ptr     <= fifo_pkg::addr_t'(1);   // head is entry 0, ram reads entry 1
         count     <= '0;
         occ       <= fifo_pkg::OCC_EMPTY;
         not_empty <= 1'b0;
         full      <= 1'b0;
         err       <= 1'b0;
         perr      <= 1'b0;
      end
      else
      begin
         if (do_write)
            w_ptr <= w_ptr + fifo_pkg::addr_t'(1);
         r_ptr     <= r_ptr_nxt;
         count     <= count_nxt;
         occ       <= occ_nxt;                   // replaces separate lt/gt flags
         not_empty <= count_nxt != '0;
         full      <= count_nxt >= fifo_pkg::count_t'(fifo_pkg::FULL_THRESHOLD);
         err       <= refused;                   // single cycle pulse
         // rdata belongs to this read, so the mismatch is judged now
         perr      <= ram.perr_raw & ram_rd_en;
      end
   end

endmodule

//--- verilog/fifo_bypass.sv
`timescale 1ns/1ns

// two-entry bypass in front of the ram, dout is the head word
module fifo_bypass
(
   input  logic             clk,
   input  logic             reset,
   input  fifo_pkg::data_t  din,
   input  logic             do_write,
   input  logic             do_read,
   input  fifo_pkg::occ_t   occ,
   input  fifo_pkg::data_t  rdata,
   output fifo_pkg::data_t  dout
);

   fifo_pkg::data_t din_q;      // last accepted word
   fifo_pkg::data_t dout_nxt;

   // --------------------
   // head select
   // --------------------
   // empty  : the new word goes straight to the head
   // one    : head leaves, so a word written now replaces it
   // two    : second word sits in din_q
   // more   : second word was prefetched by the ram
   always_comb
   begin
      dout_nxt = dout;   // hold by default
      case (occ)
         fifo_pkg::OCC_EMPTY:
         begin
            if (do_write)
               dout_nxt = din;
         end
         fifo_pkg::OCC_ONE:
         begin
            if (do_read && do_write)
               dout_nxt = din;
         end
         fifo_pkg::OCC_TWO:
         begin
            if (do_read)
               dout_nxt = din_q;
         end
         fifo_pkg::OCC_MORE:
         begin
            if (do_read)
               dout_nxt = rdata;
         end
      endcase
   end

   // --------------------
   // registers
   // --------------------
   always_ff @(posedge clk)
   begin
      if (do_write)
         din_q <= din;   // tail copy, needed once count drops to two
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dout <= '0;     // clean head after reset
      else
         dout <= dout_nxt;
   end

endmodule

//--- verilog/bfifo_top.sv
`timescale 1ns/1ns

// synchronous bypass fifo, registered outputs
module bfifo_top
(
   input  logic              clk,
   input  logic              reset,
   input  fifo_pkg::data_t   din,
   input  logic              wen,
   input  logic              ren,
   output fifo_pkg::data_t   dout,
   output logic              not_empty,
   output fifo_pkg::count_t  count,
   output logic              full,
   output logic              err,
   output logic              perr
);

   // --------------------
   // internal wiring
   // --------------------
   logic           do_write;   // accepted write
   logic           do_read;    // accepted read
   fifo_pkg::occ_t occ;        // registered occupancy class

   fifo_ram_if ram_bus ();

   // --------------------
   // control
   // --------------------
   fifo_ctrl u_ctrl
   (
      .clk       (clk),
      .reset     (reset),
      .din       (din),
      .wen       (wen),
      .ren       (ren),
      .ram       (ram_bus.ctrl),
      .do_write  (do_write),
      .do_read   (do_read),
      .occ       (occ),
      .not_empty (not_empty),
      .count     (count),
      .full      (full),
      .err       (err),
      .perr      (perr)
   );

   // storage
   fifo_ram u_ram
   (
      .clk (clk),
      .mem (ram_bus.ram)
   );

   // head and second word
   fifo_bypass u_bypass
   (
      .clk      (clk),
      .reset    (reset),
      .din      (din),
      .do_write (do_write),
      .do_read  (do_read),
      .occ      (occ),
      .rdata    (ram_bus.rdata),   // prefetched word behind the head
      .dout     (dout)
   );

endmodule

//--- tb/bfifo_chk.sv
`timescale 1ns/1ns

// protocol checks on the fifo controller, bound into every fifo_ctrl
module bfifo_chk
(
   input logic             clk,
   input logic             reset,
   input logic             wen,
   input logic             ren,
   input logic             not_empty,
   input logic             full,
   input logic             err,
   input fifo_pkg::count_t count
);

   int fail_count = 0;   // failed assertions so far

   // err is a one cycle echo of a refused write or read
   assert property (@(posedge clk) disable iff (reset)
      err |-> $past((wen && (count >= fifo_pkg::count_t'(fifo_pkg::DEPTH)))
                    || (ren && !not_empty)))
   else
   begin
      $error("err high without a refused operation in the cycle before");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (reset)
      full |-> (count >= fifo_pkg::count_t'(fifo_pkg::FULL_THRESHOLD)))
   else
   begin
      $error("full high below the threshold, count %0d", count);
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (reset)
      count <= fifo_pkg::count_t'(fifo_pkg::DEPTH))   // never more than the ram holds
   else
   begin
      $error("count %0d above depth", count);
      fail_count++;
   end

endmodule

bind fifo_ctrl bfifo_chk chk
(
   .clk       (clk),
   .reset     (reset),
   .wen       (wen),
   .ren       (ren),
   .not_empty (not_empty),
   .full      (full),
   .err       (err),
   .count     (count)
);

//--- tb/bfifo_tb.sv
`timescale 1ns/1ns

module bfifo_tb;

   localparam int FILL_CYCLES   = 2 * fifo_pkg::DEPTH + 2;   // fill, overflow, drain, underflow
   localparam int PARITY_CYCLES = 6;                         // three writes, three reads
   localparam int STRESS_CYCLES = 400;

   logic             clk;
   logic             reset;
   fifo_pkg::data_t  din;
   logic             wen;
   logic             ren;
   fifo_pkg::data_t  dout;
   logic             not_empty;
   fifo_pkg::count_t count;
   logic             full;
   logic             err;
   logic             perr;

   // directed vectors from the input file
   fifo_pkg::data_t  vec_din   [$];
   fifo_pkg::data_t  vec_dout  [$];
   fifo_pkg::count_t vec_count [$];
   logic [4:0]       vec_bits  [$];   // wen ren not_empty full err
   bit               vec_loaded;

   // expectation for the cycle in flight
   bit               exp_valid;
   fifo_pkg::data_t  exp_dout;
   logic             exp_ne;
   fifo_pkg::count_t exp_count;
   logic             exp_full;
   logic             exp_err;
   logic             exp_perr;

   fifo_pkg::data_t  model_q [$];     // reference queue, head at index 0
   logic [15:0]      lfsr;
   int               data_errors;
   int               count_errors;
   int               flag_errors;
   int               other_errors;
   int               chk_fails;

   bfifo_top dut
   (
      .clk       (clk),
      .reset     (reset),
      .din       (din),
      .wen       (wen),
      .ren       (ren),
      .dout      (dout),
      .not_empty (not_empty),
      .count     (count),
      .full      (full),
      .err       (err),
      .perr      (perr)
   );

   always #10 clk = ~clk;   // 20 ns period

   // --------------------
   // compare
   // --------------------
   task automatic check_data(input string name, input fifo_pkg::data_t got,
                             input fifo_pkg::data_t want);
      if (got !== want)
      begin
         data_errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_count(input string name, input fifo_pkg::count_t got,
                              input fifo_pkg::count_t want);
      if (got !== want)
      begin
         count_errors++;
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
      end
   endtask

   task automatic check_bit(input string name, input bit got, input bit want);
      if (got != want)
      begin
         flag_errors++;
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
      end
   endtask

   task automatic check_outputs();
      check_bit("not_empty", not_empty, exp_ne);
      check_count("count", count, exp_count);
      check_bit("full", full, exp_full);
      check_bit("err", err, exp_err);
      check_bit("perr", perr, exp_perr);       // high only after a ram read with bad parity
      if (exp_ne)
         check_data("dout", dout, exp_dout);   // dout is stale while empty
   endtask

   // drive at the rising edge, look at the outputs of the previous step mid cycle
   task automatic apply(input fifo_pkg::data_t d, input logic w, input logic r);
      @(posedge clk);
      din <= d;
      wen <= w;
      ren <= r;
      @(negedge clk);
      if (exp_valid)
         check_outputs();
   endtask

   // --------------------
   // reference model
   // --------------------
   task automatic model_step(input fifo_pkg::data_t d, input logic w, input logic r);
      logic wr_ok;
      logic rd_ok;
      wr_ok = w && (model_q.size() < fifo_pkg::DEPTH);   // a full fifo refuses even with a read
      rd_ok = r && (model_q.size() > 0);
      exp_err = (w && !wr_ok) || (r && !rd_ok);
      if (rd_ok)
         void'(model_q.pop_front());
      if (wr_ok)
         model_q.push_back(d);
      exp_ne    = model_q.size() > 0;
      exp_count = fifo_pkg::count_t'(model_q.size());
      exp_full  = model_q.size() >= fifo_pkg::FULL_THRESHOLD;
      exp_perr  = 1'b0;
      if (exp_ne)
         exp_dout = model_q[0];
      exp_valid = 1'b1;
   endtask

   task automatic run_cycle(input fifo_pkg::data_t d, input logic w, input logic r);
      apply(d, w, r);
      model_step(d, w, r);
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
   endfunction

   task automatic take_bits(input int n, output fifo_pkg::data_t v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[fifo_pkg::DATA_W-2:0], lfsr[0]};   // one step per bit
      end
   endtask

   // --------------------
   // test phases
   // --------------------
   task automatic read_vectors();
      int              fd;
      int              n;
      string           line;
      fifo_pkg::data_t f_din, f_wen, f_ren, f_dout, f_ne, f_cnt, f_full, f_err;
      fd = $fopen("tb/bfifo_input.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("cannot open tb/bfifo_input.txt");
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line[0] == "#")
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                     f_din, f_wen, f_ren, f_dout, f_ne, f_cnt, f_full, f_err);
         if (n == 8)
         begin
            vec_din.push_back(f_din);
            vec_dout.push_back(f_dout);
            vec_count.push_back(f_cnt[fifo_pkg::COUNT_W-1:0]);
            vec_bits.push_back({f_wen[0], f_ren[0], f_ne[0], f_full[0], f_err[0]});
         end
         else if (n > 0)
         begin
            other_errors++;
            $display("malformed line in tb/bfifo_input.txt: %s", line);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_vectors();
      logic [4:0] b;
      for (int i = 0; i < vec_din.size(); i++)
      begin
         b = vec_bits[i];
         apply(vec_din[i], b[4], b[3]);
         exp_dout  = vec_dout[i];
         exp_ne    = b[2];
         exp_count = vec_count[i];
         exp_full  = b[1];
         exp_err   = b[0];
         exp_valid = 1'b1;
      end
   endtask

   task automatic run_fill();
      fifo_pkg::data_t d;
      for (int i = 0; i < fifo_pkg::DEPTH; i++)
      begin
         take_bits(fifo_pkg::DATA_W, d);
         run_cycle(d, 1'b1, 1'b0);   // full rises on the way up
      end
      run_cycle('1, 1'b1, 1'b0);     // overflow, count stays at depth
      for (int i = 0; i < fifo_pkg::DEPTH; i++)
         run_cycle('0, 1'b0, 1'b1);  // drain, mostly through rdata
      run_cycle('0, 1'b0, 1'b1);     // underflow
   endtask

   // the stored parity seen by the ram is cleared while the second word is read
   task automatic run_parity();
      fifo_pkg::data_t d;
      take_bits(fifo_pkg::DATA_W, d);
      run_cycle(d, 1'b1, 1'b0);                      // head word
      run_cycle(fifo_pkg::data_t'(1), 1'b1, 1'b0);   // one bit in slice 0, parity 3'b001
      take_bits(fifo_pkg::DATA_W, d);
      run_cycle(d, 1'b1, 1'b0);                      // count three, second word in the ram
      force dut.u_ram.rd_par = '0;
      run_cycle('0, 1'b0, 1'b1);                     // dout loads from rdata
      exp_perr = 1'b1;
      run_cycle('0, 1'b0, 1'b1);                     // from din_q, ram not read
      release dut.u_ram.rd_par;
      run_cycle('0, 1'b0, 1'b1);
   endtask

   task automatic run_stress();
      fifo_pkg::data_t d;
      fifo_pkg::data_t b;
      logic            w;
      logic            r;
      for (int i = 0; i < STRESS_CYCLES; i++)
      begin
         take_bits(fifo_pkg::DATA_W, d);
         take_bits(3, b);
         if (i < STRESS_CYCLES / 2)
         begin
            w = b[0] | b[1];   // writes lead, fifo fills
            r = b[2];
         end
         else
         begin
            w = b[2];
            r = b[0] | b[1];   // reads lead, fifo drains
         end
         run_cycle(d, w, r);
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial
   begin
      clk          = 1'b0;
      reset        = 1'b1;
      din          = '0;
      wen          = 1'b0;
      ren          = 1'b0;
      lfsr         = 16'd27;
      exp_valid    = 1'b0;
      exp_perr     = 1'b0;
      data_errors  = 0;
      count_errors = 0;
      flag_errors  = 0;
      other_errors = 0;
      read_vectors();
      if (vec_din.size() == 0)
      begin
         other_errors++;
         $display("no directed vectors were read");
      end
      vec_loaded = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bit("not_empty", not_empty, 1'b0);   // state right after reset
      check_bit("full", full, 1'b0);
      check_bit("err", err, 1'b0);
      check_bit("perr", perr, 1'b0);
      check_count("count", count, '0);
      run_vectors();
      run_fill();
      run_parity();
      run_stress();
      apply('0, 1'b0, 1'b0);   // picks up the last expectation
      chk_fails = dut.u_ctrl.chk.fail_count;
      $display("error counts: dout %0d, count %0d, flags %0d, other %0d, assertions %0d",
               data_errors, count_errors, flag_errors, other_errors, chk_fails);
      if (data_errors + count_errors + flag_errors + other_errors + chk_fails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // watchdog, sized from the vector count and the generated cycles
   initial
   begin
      int limit_ns;
      wait (vec_loaded);
      limit_ns = (vec_din.size() + FILL_CYCLES + PARITY_CYCLES + STRESS_CYCLES + 20) * 20;
      #(limit_ns);
      $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- project.f
verilog/fifo_pkg.sv
verilog/fifo_ram_if.sv
verilog/fifo_ram.sv
verilog/fifo_ctrl.sv
verilog/fifo_bypass.sv
verilog/bfifo_top.sv
tb/bfifo_chk.sv
tb/bfifo_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bypass fifo testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module bfifo_tb \
   -f project.f

# keep running past assertion errors so the testbench can report them
./obj_dir/Vbfifo_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
   echo "run.sh: testbench reported failure"
   exit 1
fi
echo "run.sh: no failure found in sim.log"

//--- tb/bfifo_input.txt
# din wen ren, then the outputs expected after the edge that takes the line:
# dout not_empty count full err (all hex, dout only counts while not_empty is 1)
00000000000000000000 0 0 00000000000000000000 0 00 0 0
# single word in and out
123456789abcdef01111 1 0 123456789abcdef01111 1 01 0 0
00000000000000000000 0 1 123456789abcdef01111 0 00 0 0
# one word, then write and read together
0f0f0f0f0f0f0f0f2222 1 0 0f0f0f0f0f0f0f0f2222 1 01 0 0
f0f0f0f0f0f0f0f03333 1 1 f0f0f0f0f0f0f0f03333 1 01 0 0
00000000000000000000 0 1 f0f0f0f0f0f0f0f03333 0 00 0 0
# ten writes, head stays on the first
11111111111111111111 1 0 11111111111111111111 1 01 0 0
22222222222222222222 1 0 11111111111111111111 1 02 0 0
33333333333333333333 1 0 11111111111111111111 1 03 0 0
44444444444444444444 1 0 11111111111111111111 1 04 0 0
55555555555555555555 1 0 11111111111111111111 1 05 0 0
66666666666666666666 1 0 11111111111111111111 1 06 0 0
77777777777777777777 1 0 11111111111111111111 1 07 0 0
88888888888888888888 1 0 11111111111111111111 1 08 0 0
99999999999999999999 1 0 11111111111111111111 1 09 0 0
aaaaaaaaaaaaaaaaaaaa 1 0 11111111111111111111 1 0a 0 0
# ten reads back to back
00000000000000000000 0 1 22222222222222222222 1 09 0 0
00000000000000000000 0 1 33333333333333333333 1 08 0 0
00000000000000000000 0 1 44444444444444444444 1 07 0 0
00000000000000000000 0 1 55555555555555555555 1 06 0 0
00000000000000000000 0 1 66666666666666666666 1 05 0 0
00000000000000000000 0 1 77777777777777777777 1 04 0 0
00000000000000000000 0 1 88888888888888888888 1 03 0 0
00000000000000000000 0 1 99999999999999999999 1 02 0 0
00000000000000000000 0 1 aaaaaaaaaaaaaaaaaaaa 1 01 0 0
00000000000000000000 0 1 aaaaaaaaaaaaaaaaaaaa 0 00 0 0
# read while empty
00000000000000000000 0 1 aaaaaaaaaaaaaaaaaaaa 0 00 0 1
00000000000000000000 0 0 aaaaaaaaaaaaaaaaaaaa 0 00 0 0
